// File: rtl/line_code_pkg.sv
`default_nettype none

//////////////////////////////
// Line side of the receive path
//////////////////////////////

package line_code_pkg;

	// One 8b/10b codeword
	// Bit 9 is abcdei bit a, the first bit on the wire
	// Bits 9..4 hold the 6b block, bits 3..0 hold fghj
	typedef logic [9:0] symbol_t;

	// Decoded byte, HGF in the top three bits and EDCBA below
	typedef logic [7:0] octet_t;

	// Bits recovered in one fabric clock
	// Newest bit sits in bit 0, so the oldest used bit is bit count-1
	typedef logic [4:0] chunk_t;

	// Number of valid bits in a chunk, 0 to 5
	typedef logic [2:0] chunk_count_t;

	//////////////////////////////
	// K28.5 comma codewords
	//////////////////////////////

	// Sent while running disparity is negative
	// 001111 followed by 1010
	localparam symbol_t comma_rd_neg = 10'b0011111010;

	// Sent while running disparity is positive
	// 110000 followed by 0101
	localparam symbol_t comma_rd_pos = 10'b1100000101;

endpackage

`default_nettype wire

// File: rtl/rx_status_pkg.sv
`default_nettype none

//////////////////////////////
// Status and register side
//////////////////////////////

package rx_status_pkg;

	// One saturating event counter
	typedef logic [15:0] err_count_t;

	// APB byte address and data word
	typedef logic [3:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Register map, counters read only
	localparam apb_addr_t reg_symbol_errs = 4'h0;
	localparam apb_addr_t reg_disparity_errs = 4'h4;
	localparam apb_addr_t reg_bitslips = 4'h8;

	// Write only in effect, any write zeroes every counter
	localparam apb_addr_t reg_clear = 4'hc;

endpackage

`default_nettype wire

// File: rtl/rx_symbol_gearbox.sv
`default_nettype none
`timescale 1ns/100ps

module rx_symbol_gearbox (
	input wire clk_312p5mhz,
	input wire reset,
	input wire line_code_pkg::chunk_t rx_data,
	input wire line_code_pkg::chunk_count_t rx_data_count,
	input wire bitslip,
	output line_code_pkg::symbol_t symbol,
	output logic symbol_valid
);

	import line_code_pkg::*;

	// Bit store, newest in bit 0
	// Only the low held_count bits are meaningful
	logic [14:0] held_bits;
	logic [3:0] held_count;

	// Chunk after the slip is applied
	chunk_count_t used_count;
	chunk_t used_mask;

	// Store and fill level once this chunk is appended
	logic [14:0] merged_bits;
	logic [3:0] total_count;
	logic emit;

	//////////////////////////////
	// Append stage
	//////////////////////////////

	always_comb begin
		used_count = rx_data_count;
		// Slip drops the oldest bit of this chunk, i.e. its top used bit
		// With no bits in this cycle there is nothing to drop
		if (bitslip && (rx_data_count != 3'd0))
			used_count = rx_data_count - 3'd1;

		// Keep only the bits that survive, stale high bits are masked off
		used_mask = chunk_t'((6'd1 << used_count) - 6'd1);

		merged_bits = (held_bits << used_count) | {10'd0, rx_data & used_mask};
		total_count = held_count + {1'b0, used_count};
	end

	// Ten or more bits held means a full codeword is ready
	assign emit = (total_count >= 4'd10);

	//////////////////////////////
	// Fill level and strobe
	//////////////////////////////

	always_ff @(posedge clk_312p5mhz) begin
		if (reset) begin
			held_count <= '0;
			symbol_valid <= 1'b0;
		end else begin
			symbol_valid <= emit;
			if (emit)
				held_count <= total_count - 4'd10;
			else
				held_count <= total_count;
		end
	end

	// Bit store and output word
	always_ff @(posedge clk_312p5mhz) begin
		held_bits <= merged_bits;
		// Oldest ten bits sit just above the leftovers
		if (emit)
			symbol <= symbol_t'(merged_bits >> (total_count - 4'd10));
	end

	// Recovery block never hands over more than five bits in a clock
	chunk_in_range: assert property (@(posedge clk_312p5mhz) disable iff (reset)
		rx_data_count <= 3'd5);

	// At most nine leftovers plus five new bits, so the store never fills
	store_no_overflow: assert property (@(posedge clk_312p5mhz) disable iff (reset)
		total_count != 4'd15);

endmodule

`default_nettype wire

// File: rtl/decode_8b10b.sv
`default_nettype none
`timescale 1ns/100ps

module decode_8b10b #(
	parameter int loss_threshold = 4,
	parameter int slip_settle = 2
) (
	input wire clk_312p5mhz,
	input wire reset,
	input wire line_code_pkg::symbol_t symbol,
	input wire symbol_valid,
	output logic data_valid,
	output line_code_pkg::octet_t data,
	output logic data_is_ctl,
	output logic disparity_err,
	output logic symbol_err,
	output logic bitslip,
	output logic locked
);

	import line_code_pkg::*;

	localparam int bad_w = $clog2(loss_threshold + 1);
	localparam int settle_w = $clog2(slip_settle + 1);

	typedef enum logic [1:0] {st_hunt, st_settle, st_locked} lock_state_t;

	lock_state_t state;
	logic [bad_w-1:0] bad_count;
	logic [settle_w-1:0] settle_count;
	// Running disparity, high when positive
	logic rd_pos;

	logic [5:0] code6;
	logic [3:0] code4;
	logic [3:0] code4_norm;
	logic [4:0] dec5;
	logic [2:0] dec3;
	logic valid6;
	logic valid4;
	logic is_k28;
	logic is_a7;
	logic is_kx7;
	logic a7_ok;
	logic is_comma;
	logic bad_code;
	logic need_neg6;
	logic need_pos6;
	logic need_neg4;
	logic need_pos4;
	logic rd_mid;
	logic rd_next;
	logic bad_disp;

	assign code6 = symbol[9:4];
	assign code4 = symbol[3:0];

	//////////////////////////////
	// 6b/5b lookup
	//////////////////////////////

	always_comb begin
		valid6 = 1'b1;
		case (code6)
			6'b100111, 6'b011000: dec5 = 5'd0;
			6'b011101, 6'b100010: dec5 = 5'd1;
			6'b101101, 6'b010010: dec5 = 5'd2;
			6'b110001: dec5 = 5'd3;
			6'b110101, 6'b001010: dec5 = 5'd4;
			6'b101001: dec5 = 5'd5;
			6'b011001: dec5 = 5'd6;
			6'b111000, 6'b000111: dec5 = 5'd7;
			6'b111001, 6'b000110: dec5 = 5'd8;
			6'b100101: dec5 = 5'd9;
			6'b010101: dec5 = 5'd10;
			6'b110100: dec5 = 5'd11;
			6'b001101: dec5 = 5'd12;
			6'b101100: dec5 = 5'd13;
			6'b011100: dec5 = 5'd14;
			6'b010111, 6'b101000: dec5 = 5'd15;
			6'b011011, 6'b100100: dec5 = 5'd16;
			6'b100011: dec5 = 5'd17;
			6'b010011: dec5 = 5'd18;
			6'b110010: dec5 = 5'd19;
			6'b001011: dec5 = 5'd20;
			6'b101010: dec5 = 5'd21;
			6'b011010: dec5 = 5'd22;
			6'b111010, 6'b000101: dec5 = 5'd23;
			6'b110011, 6'b001100: dec5 = 5'd24;
			6'b100110: dec5 = 5'd25;
			6'b010110: dec5 = 5'd26;
			6'b110110, 6'b001001: dec5 = 5'd27;
			6'b001110: dec5 = 5'd28;
			6'b101110, 6'b010001: dec5 = 5'd29;
			6'b011110, 6'b100001: dec5 = 5'd30;
			6'b101011, 6'b010100: dec5 = 5'd31;
			// K28 prefix
			6'b001111, 6'b110000: dec5 = 5'd28;
			default: begin
				dec5 = 5'd0;
				valid6 = 1'b0;
			end
		endcase
	end

	//////////////////////////////
	// 4b/3b lookup
	//////////////////////////////

	// The RD+ K28 prefix is followed by the complemented 4b block
	assign code4_norm = (code6 == 6'b110000) ? ~code4 : code4;

	always_comb begin
		valid4 = 1'b1;
		case (code4_norm)
			4'b1011, 4'b0100: dec3 = 3'd0;
			4'b1001: dec3 = 3'd1;
			4'b0101: dec3 = 3'd2;
			4'b1100, 4'b0011: dec3 = 3'd3;
			4'b1101, 4'b0010: dec3 = 3'd4;
			4'b1010: dec3 = 3'd5;
			4'b0110: dec3 = 3'd6;
			// Primary and alternate forms of .7
			4'b1110, 4'b0001, 4'b0111, 4'b1000: dec3 = 3'd7;
			default: begin
				dec3 = 3'd0;
				valid4 = 1'b0;
			end
		endcase
	end

	// Control codes are K28.y plus K23.7, K27.7, K29.7, K30.7
	assign is_k28 = (code6 == 6'b001111) || (code6 == 6'b110000);
	assign is_a7 = (code4_norm == 4'b0111) || (code4_norm == 4'b1000);
	assign is_kx7 = is_a7 && valid6 && !is_k28 &&
		((dec5 == 5'd23) || (dec5 == 5'd27) || (dec5 == 5'd29) || (dec5 == 5'd30));

	// Data only takes A7 after x=17,18,20 at RD- or x=11,13,14 at RD+
	assign a7_ok = ((code4 == 4'b0111) &&
			((code6 == 6'b100011) || (code6 == 6'b010011) || (code6 == 6'b001011))) ||
		((code4 == 4'b1000) &&
			((code6 == 6'b110100) || (code6 == 6'b101100) || (code6 == 6'b011100)));

	assign bad_code = !valid6 || !valid4 ||
		(is_a7 && !is_k28 && !is_kx7 && !a7_ok) ||
		(is_k28 && ((code4_norm == 4'b1110) || (code4_norm == 4'b0001)));

	assign is_comma = (symbol == comma_rd_neg) || (symbol == comma_rd_pos);

	//////////////////////////////
	// Running disparity
	//////////////////////////////

	// D.7 and D.x.3 are balanced but still tied to one disparity
	assign need_neg6 = ($countones(code6) == 4) || (code6 == 6'b111000);
	assign need_pos6 = ($countones(code6) == 2) || (code6 == 6'b000111);
	assign need_neg4 = ($countones(code4) == 3) || (code4 == 4'b1100);
	assign need_pos4 = ($countones(code4) == 1) || (code4 == 4'b0011);

	// Disparity after each sub-block, taken from the received bits
	assign rd_mid = ($countones(code6) == 4) ? 1'b1 :
		($countones(code6) == 2) ? 1'b0 : rd_pos;
	assign rd_next = ($countones(code4) == 3) ? 1'b1 :
		($countones(code4) == 1) ? 1'b0 : rd_mid;

	assign bad_disp = (need_neg6 && rd_pos) || (need_pos6 && !rd_pos) ||
		(need_neg4 && rd_mid) || (need_pos4 && !rd_mid);

	//////////////////////////////
	// Lock FSM and output stage
	//////////////////////////////

	always_ff @(posedge clk_312p5mhz) begin
		if (reset) begin
			state <= st_hunt;
			bad_count <= '0;
			settle_count <= '0;
			rd_pos <= 1'b0;
			bitslip <= 1'b0;
			data_valid <= 1'b0;
			disparity_err <= 1'b0;
			symbol_err <= 1'b0;
		end else begin
			bitslip <= 1'b0;
			data_valid <= 1'b0;
			disparity_err <= 1'b0;
			symbol_err <= 1'b0;
			if (symbol_valid) begin
				rd_pos <= rd_next;
				// The comma that gains lock is passed on too
				data_valid <= (state == st_locked) || is_comma;
				// Errors only count once aligned
				disparity_err <= (state == st_locked) && bad_disp;
				symbol_err <= (state == st_locked) && bad_code;
				case (state)
					st_hunt: begin
						if (is_comma) begin
							state <= st_locked;
							bad_count <= '0;
						end else begin
							bitslip <= 1'b1;
							settle_count <= '0;
							state <= st_settle;
						end
					end
					// Slip reaches the decoder a symbol or so later
					st_settle: begin
						if (is_comma) begin
							state <= st_locked;
							bad_count <= '0;
						end else if (settle_count == settle_w'(slip_settle - 1)) begin
							state <= st_hunt;
						end else begin
							settle_count <= settle_count + 1'b1;
						end
					end
					default: begin
						if (!bad_code)
							bad_count <= '0;
						else if (bad_count == bad_w'(loss_threshold - 1))
							state <= st_hunt;
						else
							bad_count <= bad_count + 1'b1;
					end
				endcase
			end
		end
	end

	// Octet payload
	always_ff @(posedge clk_312p5mhz) begin
		if (symbol_valid) begin
			data <= {dec3, dec5};
			data_is_ctl <= is_k28 || is_kx7;
		end
	end

	assign locked = (state == st_locked);

	// Once aligned the boundary must stay put
	no_slip_when_locked: assert property (@(posedge clk_312p5mhz) disable iff (reset)
		locked |-> !bitslip);

endmodule

`default_nettype wire

// File: rtl/rx_error_counters.sv
`default_nettype none
`timescale 1ns/100ps

module rx_error_counters (
	input wire clk_312p5mhz,
	input wire reset,
	input wire symbol_err,
	input wire disparity_err,
	input wire bitslip,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire rx_status_pkg::apb_addr_t paddr,
	input wire rx_status_pkg::apb_data_t pwdata,
	output rx_status_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	import rx_status_pkg::*;

	// Index 0 symbol errors, 1 disparity errors, 2 bit slips
	err_count_t counts [3];
	logic [2:0] events;

	logic access;
	logic clear;
	logic addr_ok;

	assign events = {bitslip, disparity_err, symbol_err};

	// APB access phase, never stretched
	assign access = psel && penable;
	assign clear = access && pwrite && (paddr == reg_clear);

	//////////////////////////////
	// Counters
	//////////////////////////////

	always_ff @(posedge clk_312p5mhz) begin
		for (int i = 0; i < 3; i++) begin
			// Clear beats a same-cycle event
			if (reset || clear)
				counts[i] <= '0;
			else if (events[i] && (counts[i] != '1))
				counts[i] <= counts[i] + 1'b1;
		end
	end

	//////////////////////////////
	// Register read and response
	//////////////////////////////

	// Read sees the value before any update in this cycle
	always_comb begin
		prdata = '0;
		addr_ok = 1'b1;
		case (paddr)
			reg_symbol_errs: prdata[15:0] = counts[0];
			reg_disparity_errs: prdata[15:0] = counts[1];
			reg_bitslips: prdata[15:0] = counts[2];
			// Clear register reads back as zero
			reg_clear: prdata = '0;
			default: addr_ok = 1'b0;
		endcase
	end

	// No wait states
	assign pready = 1'b1;

	// Counter registers refuse writes, unmapped offsets refuse everything
	assign pslverr = access && (!addr_ok || (pwrite && (paddr != reg_clear)));

	// Access phase only follows a setup phase of the same transfer
	penable_needs_psel: assert property (@(posedge clk_312p5mhz) disable iff (reset)
		penable |-> psel);

endmodule

`default_nettype wire

// File: rtl/sgmii_rx_path.sv
`default_nettype none
`timescale 1ns/100ps

module sgmii_rx_path #(
	parameter int loss_threshold = 4,
	parameter int slip_settle = 2
) (
	input wire clk_312p5mhz,
	input wire reset,
	// Recovered line bits
	input wire line_code_pkg::chunk_t rx_data,
	input wire line_code_pkg::chunk_count_t rx_data_count,
	// Decoded stream
	output logic data_valid,
	output line_code_pkg::octet_t data,
	output logic data_is_ctl,
	output logic disparity_err,
	output logic symbol_err,
	output logic locked,
	// Counter registers
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire rx_status_pkg::apb_addr_t paddr,
	input wire rx_status_pkg::apb_data_t pwdata,
	output rx_status_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	import line_code_pkg::*;

	symbol_t symbol;
	logic symbol_valid;
	// Decoder asks the gearbox to drop one bit
	logic bitslip;

	//////////////////////////////
	// Chunks to codewords
	//////////////////////////////

	rx_symbol_gearbox i_gearbox (
		.clk_312p5mhz, .reset,
		.rx_data, .rx_data_count, .bitslip,
		.symbol, .symbol_valid
	);

	// Codewords to octets, alignment
	decode_8b10b #(
		.loss_threshold(loss_threshold),
		.slip_settle(slip_settle)
	) i_decoder (
		.clk_312p5mhz, .reset,
		.symbol, .symbol_valid,
		.data_valid, .data, .data_is_ctl,
		.disparity_err, .symbol_err, .bitslip, .locked
	);

	// Event counters behind APB
	rx_error_counters i_counters (
		.clk_312p5mhz, .reset,
		.symbol_err, .disparity_err, .bitslip,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr
	);

endmodule

`default_nettype wire

// File: tb/rx_path_checker.sv
`default_nettype none
`timescale 1ns/100ps

module rx_path_checker (
	input wire clk_312p5mhz,
	input wire reset,
	input wire data_valid,
	input wire line_code_pkg::octet_t data,
	input wire data_is_ctl,
	input wire disparity_err,
	input wire symbol_err,
	output int fail_count,
	output int pass_count,
	output logic rows_done
);

	import line_code_pkg::*;

	// Expected decoder events in stream order
	string names[$];
	octet_t exp_data[$];
	logic exp_ctl[$];
	logic exp_sym[$];
	logic exp_disp[$];
	// Row follows a preamble whose events are alignment traffic
	logic exp_resync[$];

	int next_row = 0;
	int stream_fails = 0;
	int stream_passes = 0;
	int value_fails = 0;
	int value_passes = 0;

	assign fail_count = stream_fails + value_fails;
	assign pass_count = stream_passes + value_passes;
	assign rows_done = (names.size() != 0) && (next_row == names.size());

	task automatic add_row(input string name, input octet_t d, input logic ctl,
			input logic sym, input logic disp, input logic resync);
		names.push_back(name);
		exp_data.push_back(d);
		exp_ctl.push_back(ctl);
		exp_sym.push_back(sym);
		exp_disp.push_back(disp);
		exp_resync.push_back(resync);
	endtask

	// Scalar compare for register reads and event counts
	task automatic check_value(input string name, input int expected, input int actual);
		if (expected == actual) begin
			value_passes++;
			$display("ok   %s", name);
		end else begin
			value_fails++;
			$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// Field text for one decoder event
	function automatic string event_text(input octet_t d, input logic ctl, input logic sym,
			input logic disp);
		return $sformatf("data=%h ctl=%b sym=%b disp=%b", d, ctl, sym, disp);
	endfunction

	//////////////////////////////
	// Decoded stream
	//////////////////////////////

	always @(posedge clk_312p5mhz) begin
		if (!reset && data_valid) begin
			if (next_row >= names.size()) begin
				stream_fails++;
				$display("Decoder produced a byte after the last expected test");
			end else if (exp_resync[next_row] && !(data == exp_data[next_row] &&
					data_is_ctl == exp_ctl[next_row] && !symbol_err)) begin
				// Preamble bytes ahead of the row are not compared
			end else begin
				// Octet only means something when the codeword is valid
				if ((symbol_err != exp_sym[next_row]) ||
						(disparity_err != exp_disp[next_row]) ||
						(!exp_sym[next_row] && ((data != exp_data[next_row]) ||
						(data_is_ctl != exp_ctl[next_row])))) begin
					stream_fails++;
					$display("CHECK FAILED %s expected %s actual %s", names[next_row],
						event_text(exp_data[next_row], exp_ctl[next_row],
							exp_sym[next_row], exp_disp[next_row]),
						event_text(data, data_is_ctl, symbol_err, disparity_err));
				end else begin
					stream_passes++;
					$display("ok   %s", names[next_row]);
				end
				next_row++;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_sgmii_rx_path.sv
`default_nettype none
`timescale 1ns/100ps

module tb_sgmii_rx_path;

	import line_code_pkg::*;
	import rx_status_pkg::*;

	localparam int n_rows = 18;
	localparam int idle_pairs = 16;
	localparam int seed = 32'h8f2b_3b15;
	// D16.2 at positive disparity, second half of /I2/
	localparam symbol_t d16_2_rd_pos = 10'b1001000101;

	logic clk_312p5mhz;
	logic reset;
	chunk_t rx_data;
	chunk_count_t rx_data_count;
	logic data_valid;
	octet_t data;
	logic data_is_ctl;
	logic disparity_err;
	logic symbol_err;
	logic locked;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;

	int fail_count;
	int pass_count;
	logic rows_done;

	// Stimulus table
	string row_name [n_rows];
	symbol_t row_code [n_rows];
	octet_t row_data [n_rows];
	logic row_ctl [n_rows];
	logic row_sym [n_rows];
	logic row_disp [n_rows];
	logic row_resync [n_rows];

	// Line bits in wire order
	logic bit_q [$];
	int k;
	int lock_rises = 0;
	int lock_drops = 0;
	logic locked_d = 1'b0;

	sgmii_rx_path #(.loss_threshold(4), .slip_settle(2)) i_dut (
		.clk_312p5mhz, .reset, .rx_data, .rx_data_count,
		.data_valid, .data, .data_is_ctl, .disparity_err, .symbol_err, .locked,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
	);

	rx_path_checker i_checker (
		.clk_312p5mhz, .reset, .data_valid, .data, .data_is_ctl,
		.disparity_err, .symbol_err, .fail_count, .pass_count, .rows_done
	);

	always #100 clk_312p5mhz = ~clk_312p5mhz;

	// Lock edges, for the loss and regain checks
	always @(posedge clk_312p5mhz) begin
		locked_d <= locked;
		if (locked && !locked_d)
			lock_rises <= lock_rises + 1;
		if (!locked && locked_d)
			lock_drops <= lock_drops + 1;
	end

	task automatic set_row(input int i, input string name, input symbol_t code,
			input octet_t d, input logic ctl, input logic sym, input logic disp,
			input logic resync);
		row_name[i] = name;
		row_code[i] = code;
		row_data[i] = d;
		row_ctl[i] = ctl;
		row_sym[i] = sym;
		row_disp[i] = disp;
		row_resync[i] = resync;
	endtask

	task automatic push_symbol(input symbol_t s);
		for (int b = 9; b >= 0; b--)
			bit_q.push_back(s[b]);
	endtask

	// Random filler, then /I2/ pairs starting at negative disparity
	task automatic push_preamble(input int filler);
		for (int i = 0; i < filler; i++)
			bit_q.push_back(1'($urandom % 2));
		for (int i = 0; i < idle_pairs; i++) begin
			push_symbol(comma_rd_neg);
			push_symbol(d16_2_rd_pos);
		end
	endtask

	// Oldest bit of a chunk goes to bit count-1
	task automatic serialize_stream;
		int n;
		while (bit_q.size() > 0) begin
			@(negedge clk_312p5mhz);
			n = 2 + int'($urandom % 4);
			if (n > bit_q.size())
				n = bit_q.size();
			rx_data = '0;
			for (int i = 0; i < n; i++)
				rx_data[n - 1 - i] = bit_q.pop_front();
			rx_data_count = chunk_count_t'(n);
		end
		@(negedge clk_312p5mhz);
		rx_data = '0;
		rx_data_count = '0;
	endtask

	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		@(negedge clk_312p5mhz);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk_312p5mhz);
		penable = 1'b1;
		do
			@(posedge clk_312p5mhz);
		while (!pready);
		rdata = prdata;
		err = pslverr;
		@(negedge clk_312p5mhz);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		apb_data_t rd;
		logic err;
		int exp_sym;
		int exp_disp;
		clk_312p5mhz = 1'b0;
		reset = 1'b1;
		rx_data = '0;
		rx_data_count = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		exp_sym = 0;
		exp_disp = 0;
		void'($urandom(seed));
		k = int'($urandom % 10);
		$display("Preamble filler bits %0d", k);

		// Codewords by hand, running disparity negative between rows unless noted
		set_row(0, "k27_7_start", 10'b1101101000, 8'hfb, 1, 0, 0, 1);
		set_row(1, "d0_0", 10'b1001110100, 8'h00, 0, 0, 0, 0);
		set_row(2, "d21_5", 10'b1010101010, 8'hb5, 0, 0, 0, 0);
		set_row(3, "d3_3", 10'b1100011100, 8'h63, 0, 0, 0, 0);
		set_row(4, "k28_0", 10'b0011110100, 8'h1c, 1, 0, 0, 0);
		set_row(5, "d7_1", 10'b1110001001, 8'h27, 0, 0, 0, 0);
		// Positive form sent at negative disparity, leaves disparity positive
		set_row(6, "d0_0_wrong_rd", 10'b0110001011, 8'h00, 0, 0, 1, 0);
		set_row(7, "d16_2_rd_pos", 10'b1001000101, 8'h50, 0, 0, 0, 0);
		set_row(8, "invalid_code", 10'b0000011111, 8'h00, 0, 1, 0, 0);
		set_row(9, "d10_2", 10'b0101010101, 8'h4a, 0, 0, 0, 0);
		set_row(10, "loss_1", 10'b0000011111, 8'h00, 0, 1, 0, 0);
		set_row(11, "loss_2", 10'b0000011111, 8'h00, 0, 1, 0, 0);
		set_row(12, "loss_3", 10'b0000011111, 8'h00, 0, 1, 0, 0);
		set_row(13, "loss_4", 10'b0000011111, 8'h00, 0, 1, 0, 0);
		set_row(14, "k27_7_relock", 10'b1101101000, 8'hfb, 1, 0, 0, 1);
		set_row(15, "d5_6", 10'b1010010110, 8'hc5, 0, 0, 0, 0);
		set_row(16, "k28_5", comma_rd_neg, 8'hbc, 1, 0, 0, 0);
		set_row(17, "d16_2_tail", d16_2_rd_pos, 8'h50, 0, 0, 0, 0);

		for (int i = 0; i < n_rows; i++) begin
			if (row_resync[i])
				push_preamble((i == 0) ? k : 0);
			push_symbol(row_code[i]);
			i_checker.add_row(row_name[i], row_data[i], row_ctl[i], row_sym[i],
				row_disp[i], row_resync[i]);
			exp_sym += int'(row_sym[i]);
			exp_disp += int'(row_disp[i]);
		end

		repeat (3) @(posedge clk_312p5mhz);
		@(negedge clk_312p5mhz);
		reset = 1'b0;

		serialize_stream();
		while (!rows_done)
			@(posedge clk_312p5mhz);
		repeat (2) @(posedge clk_312p5mhz);

		i_checker.check_value("lock_rises", 2, lock_rises);
		i_checker.check_value("lock_drops", 1, lock_drops);

		// Counter readback
		apb_access(1'b0, reg_symbol_errs, '0, rd, err);
		i_checker.check_value("symbol_err_count", exp_sym, int'(rd));
		apb_access(1'b0, reg_disparity_errs, '0, rd, err);
		i_checker.check_value("disparity_err_count", exp_disp, int'(rd));
		apb_access(1'b0, reg_bitslips, '0, rd, err);
		i_checker.check_value("bitslip_count", k, int'(rd));
		i_checker.check_value("read_no_slverr", 0, int'(err));

		// Clear, then all counts read zero
		apb_access(1'b1, reg_clear, 32'h1, rd, err);
		i_checker.check_value("clear_no_slverr", 0, int'(err));
		apb_access(1'b0, reg_symbol_errs, '0, rd, err);
		i_checker.check_value("symbol_err_cleared", 0, int'(rd));
		apb_access(1'b0, reg_disparity_errs, '0, rd, err);
		i_checker.check_value("disparity_err_cleared", 0, int'(rd));
		apb_access(1'b0, reg_bitslips, '0, rd, err);
		i_checker.check_value("bitslip_cleared", 0, int'(rd));

		// Error responses
		apb_access(1'b0, 4'h2, '0, rd, err);
		i_checker.check_value("unmapped_slverr", 1, int'(err));
		apb_access(1'b1, reg_symbol_errs, 32'h5, rd, err);
		i_checker.check_value("counter_write_slverr", 1, int'(err));

		$display("Tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && rows_done) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Run length bound from the table size
	initial begin
		repeat (n_rows * 20 + 500) @(posedge clk_312p5mhz);
		$display("Watchdog expired before all tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sgmii_rx_path.f
rtl/line_code_pkg.sv
rtl/rx_status_pkg.sv
rtl/rx_symbol_gearbox.sv
rtl/decode_8b10b.sv
rtl/rx_error_counters.sv
rtl/sgmii_rx_path.sv
tb/rx_path_checker.sv
tb/tb_sgmii_rx_path.sv

// File: Makefile
# Verilator build for the SGMII receive path testbench

TOP := tb_sgmii_rx_path

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -f sgmii_rx_path.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
